//--- logic/dcache_pkg.sv
package dcache_pkg;

  // geometry
  localparam int WORD_W      = 32;
  localparam int TAG_W       = 26; // addr[31:6]
  localparam int IDX_W       = 3;  // addr[5:3]
  localparam int NUM_SETS    = 8;
  localparam int NUM_WAYS    = 2;  // one lru bit per set only covers two ways
  localparam int BLOCK_WORDS = 2;  // word select is addr[2]
  localparam int BYTE_OFF_W  = 2;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [TAG_W-1:0]  tag_t;
  typedef logic [IDX_W-1:0]  idx_t;

  // the four flush states must stay consecutive
  // the controller steps through them by adding one
  typedef enum logic [3:0] {
    IDLE,
    FETCH1, // fill word 0
    FETCH2, // fill word 1 and set valid
    WB1,    // evict word 0
    WB2,    // evict word 1
    FLUSH1, // way 0 word 0
    FLUSH2, // way 0 word 1
    FLUSH3, // way 1 word 0
    FLUSH4, // way 1 word 1 then next set
    DONE    // flushed with the array held clear
  } ctrl_state_t;

endpackage

//--- logic/dcache_array.sv
`timescale 1ns/1ps

module dcache_array (
  input  logic                 CLK,
  input  logic                 nRST,
  input  dcache_pkg::idx_t     rq_index,
  input  dcache_pkg::idx_t     fl_index,
  // single write port driven by the controller
  input  logic                 wen,
  input  logic                 wr_way,
  input  dcache_pkg::idx_t     wr_index,
  input  logic                 wr_word,
  input  dcache_pkg::tag_t     wr_tag,
  input  dcache_pkg::word_t    wr_data,
  input  logic                 wr_valid,
  input  logic                 wr_dirty,
  input  logic                 clear,
  input  logic                 lru_wen,
  input  logic                 lru_val,
  // requested set
  output dcache_pkg::tag_t     rq_tag0,
  output dcache_pkg::tag_t     rq_tag1,
  output logic                 rq_valid0,
  output logic                 rq_valid1,
  output logic                 rq_dirty0,
  output logic                 rq_dirty1,
  output dcache_pkg::word_t [dcache_pkg::BLOCK_WORDS-1:0] rq_data0,
  output dcache_pkg::word_t [dcache_pkg::BLOCK_WORDS-1:0] rq_data1,
  output logic                 rq_lru,
  // flush set
  output dcache_pkg::tag_t     fl_tag0,
  output dcache_pkg::tag_t     fl_tag1,
  output logic                 fl_dirty0,
  output logic                 fl_dirty1,
  output dcache_pkg::word_t [dcache_pkg::BLOCK_WORDS-1:0] fl_data0,
  output dcache_pkg::word_t [dcache_pkg::BLOCK_WORDS-1:0] fl_data1
);

  // tag and data payload per way and set
  dcache_pkg::tag_t tags [dcache_pkg::NUM_WAYS][dcache_pkg::NUM_SETS];
  dcache_pkg::word_t [dcache_pkg::BLOCK_WORDS-1:0] data
    [dcache_pkg::NUM_WAYS][dcache_pkg::NUM_SETS];

  // control bits indexed [way][set]
  logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::NUM_SETS-1:0] valid;
  logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::NUM_SETS-1:0] dirty;
  logic [dcache_pkg::NUM_SETS-1:0] lru; // way to evict next

  always_ff @(posedge CLK) begin
    if (wen) begin
      tags[wr_way][wr_index]          <= wr_tag;
      data[wr_way][wr_index][wr_word] <= wr_data; // one word per write
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid <= '0;
      dirty <= '0;
      lru   <= '0;
    end else if (clear) begin
      valid <= '0; // back to all invalid after the flush
      dirty <= '0;
      lru   <= '0;
    end else begin
      if (wen) begin
        valid[wr_way][wr_index] <= wr_valid;
        dirty[wr_way][wr_index] <= wr_dirty; // dirty is per block
      end
      if (lru_wen) begin
        lru[rq_index] <= lru_val; // lru always follows the requested set
      end
    end
  end

  // requested set read port
  assign rq_tag0   = tags[0][rq_index];
  assign rq_tag1   = tags[1][rq_index];
  assign rq_valid0 = valid[0][rq_index];
  assign rq_valid1 = valid[1][rq_index];
  assign rq_dirty0 = dirty[0][rq_index];
  assign rq_dirty1 = dirty[1][rq_index];
  assign rq_data0  = data[0][rq_index];
  assign rq_data1  = data[1][rq_index];
  assign rq_lru    = lru[rq_index];

  // dirty implies valid so the flush port has no valid
  assign fl_tag0   = tags[0][fl_index];
  assign fl_tag1   = tags[1][fl_index];
  assign fl_dirty0 = dirty[0][fl_index];
  assign fl_dirty1 = dirty[1][fl_index];
  assign fl_data0  = data[0][fl_index];
  assign fl_data1  = data[1][fl_index];

endmodule

//--- logic/dcache_lookup.sv
`timescale 1ns/1ps

module dcache_lookup (
  input  dcache_pkg::word_t    dmemaddr,
  input  logic                 dmemREN,
  input  logic                 dmemWEN,
  input  dcache_pkg::tag_t     rq_tag0,
  input  dcache_pkg::tag_t     rq_tag1,
  input  logic                 rq_valid0,
  input  logic                 rq_valid1,
  input  logic                 rq_dirty0,
  input  logic                 rq_dirty1,
  input  dcache_pkg::word_t [dcache_pkg::BLOCK_WORDS-1:0] rq_data0,
  input  dcache_pkg::word_t [dcache_pkg::BLOCK_WORDS-1:0] rq_data1,
  input  logic                 rq_lru,
  output dcache_pkg::idx_t     rq_index,
  output logic                 hit,
  output logic                 hit_way,
  output dcache_pkg::word_t    dmemload,
  output logic                 victim_way,
  output logic                 victim_valid,
  output logic                 victim_dirty,
  output dcache_pkg::tag_t     victim_tag,
  output dcache_pkg::word_t [dcache_pkg::BLOCK_WORDS-1:0] victim_data
);

  dcache_pkg::tag_t rq_tag;
  logic rq_off;
  logic req;
  logic hit0;
  logic hit1;

  // address split into tag, index, word and byte
  assign rq_tag   = dmemaddr[31:6];
  assign rq_index = dmemaddr[5:3];
  assign rq_off   = dmemaddr[2];

  assign req  = dmemREN | dmemWEN; // no hit without a request
  assign hit0 = req && rq_valid0 && (rq_tag0 == rq_tag);
  assign hit1 = req && rq_valid1 && (rq_tag1 == rq_tag);

  assign hit     = hit0 | hit1;
  assign hit_way = hit1; // both ways never match at once

  // load word is zero while missing
  always_comb begin
    if (hit0) begin
      dmemload = rq_data0[rq_off];
    end else if (hit1) begin
      dmemload = rq_data1[rq_off];
    end else begin
      dmemload = '0;
    end
  end

  // hit way on a hit and lru way on a miss
  assign victim_way   = hit ? hit_way : rq_lru;
  assign victim_valid = victim_way ? rq_valid1 : rq_valid0;
  assign victim_dirty = victim_way ? rq_dirty1 : rq_dirty0;
  assign victim_tag   = victim_way ? rq_tag1 : rq_tag0;   // for eviction address
  assign victim_data  = victim_way ? rq_data1 : rq_data0;

endmodule

//--- logic/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
  input  logic                 CLK,
  input  logic                 nRST,
  // processor
  input  dcache_pkg::word_t    dmemaddr,
  input  logic                 dmemREN,
  input  logic                 dmemWEN,
  input  dcache_pkg::word_t    dmemstore,
  input  logic                 halt,
  output logic                 flushed,
  // lookup
  input  logic                 hit,
  input  logic                 hit_way,
  input  logic                 victim_way,
  input  logic                 victim_valid,
  input  logic                 victim_dirty,
  input  dcache_pkg::tag_t     victim_tag,
  input  dcache_pkg::word_t [dcache_pkg::BLOCK_WORDS-1:0] victim_data,
  // array flush port
  input  dcache_pkg::tag_t     fl_tag0,
  input  dcache_pkg::tag_t     fl_tag1,
  input  logic                 fl_dirty0,
  input  logic                 fl_dirty1,
  input  dcache_pkg::word_t [dcache_pkg::BLOCK_WORDS-1:0] fl_data0,
  input  dcache_pkg::word_t [dcache_pkg::BLOCK_WORDS-1:0] fl_data1,
  output dcache_pkg::idx_t     fl_index,
  // array write port
  output logic                 wen,
  output logic                 wr_way,
  output dcache_pkg::idx_t     wr_index,
  output logic                 wr_word,
  output dcache_pkg::tag_t     wr_tag,
  output dcache_pkg::word_t    wr_data,
  output logic                 wr_valid,
  output logic                 wr_dirty,
  output logic                 clear,
  output logic                 lru_wen,
  output logic                 lru_val,
  // memory
  output logic                 dREN,
  output logic                 dWEN,
  output dcache_pkg::word_t    daddr,
  output dcache_pkg::word_t    dstore,
  input  dcache_pkg::word_t    dload,
  input  logic                 dwait
);

  localparam logic [dcache_pkg::BYTE_OFF_W-1:0] BYTE0 = '0;

  dcache_pkg::ctrl_state_t state;
  dcache_pkg::ctrl_state_t next_state;

  dcache_pkg::tag_t rq_tag;
  dcache_pkg::idx_t rq_index;
  logic rq_off;

  // word of the flush set currently offered to memory
  logic fl_way;
  logic fl_word;
  logic fsel_dirty;
  dcache_pkg::tag_t fsel_tag;
  dcache_pkg::word_t [dcache_pkg::BLOCK_WORDS-1:0] fsel_data;
  logic fl_inc;

  assign rq_tag   = dmemaddr[31:6];
  assign rq_index = dmemaddr[5:3];
  assign rq_off   = dmemaddr[2];

  // FLUSH1..4 walk way0 w0, way0 w1, way1 w0, way1 w1
  assign fl_way     = (state == dcache_pkg::FLUSH3) || (state == dcache_pkg::FLUSH4);
  assign fl_word    = (state == dcache_pkg::FLUSH2) || (state == dcache_pkg::FLUSH4);
  assign fsel_dirty = fl_way ? fl_dirty1 : fl_dirty0;
  assign fsel_tag   = fl_way ? fl_tag1 : fl_tag0;
  assign fsel_data  = fl_way ? fl_data1 : fl_data0;

  assign flushed = (state == dcache_pkg::DONE); // sticky until reset

  always_comb begin
    next_state = state;
    dREN       = 1'b0;
    dWEN       = 1'b0;
    daddr      = '0;
    dstore     = '0;
    wen        = 1'b0;
    wr_way     = victim_way; // fill target unless a write hit
    wr_index   = rq_index;
    wr_word    = rq_off;
    wr_tag     = rq_tag;
    wr_data    = dload;
    wr_valid   = 1'b0;
    wr_dirty   = 1'b0;
    clear      = 1'b0;
    lru_wen    = 1'b0;
    lru_val    = ~hit_way; // point away from the way just used
    fl_inc     = 1'b0;

    case (state)
      dcache_pkg::IDLE: begin
        if (halt) begin
          next_state = dcache_pkg::FLUSH1; // halt wins over any request
        end else if (hit) begin
          lru_wen = 1'b1;
          if (dmemWEN) begin
            wen      = 1'b1;
            wr_way   = hit_way;
            wr_data  = dmemstore;
            wr_valid = 1'b1;
            wr_dirty = 1'b1;
          end
        end else if (dmemREN || dmemWEN) begin
          if (victim_valid && victim_dirty) begin
            next_state = dcache_pkg::WB1;
          end else begin
            next_state = dcache_pkg::FETCH1;
          end
        end
      end

      dcache_pkg::FETCH1: begin
        dREN    = 1'b1;
        daddr   = {rq_tag, rq_index, 1'b0, BYTE0};
        wr_word = 1'b0;
        wen     = ~dwait; // tag goes in now while the line stays invalid
        if (!dwait) begin
          next_state = dcache_pkg::FETCH2;
        end
      end

      dcache_pkg::FETCH2: begin
        dREN     = 1'b1;
        daddr    = {rq_tag, rq_index, 1'b1, BYTE0};
        wr_word  = 1'b1;
        wr_valid = 1'b1; // block complete with this word
        wen      = ~dwait;
        if (!dwait) begin
          next_state = dcache_pkg::IDLE; // request hits next cycle
        end
      end

      dcache_pkg::WB1: begin
        dWEN   = 1'b1;
        daddr  = {victim_tag, rq_index, 1'b0, BYTE0}; // rebuilt from stored tag
        dstore = victim_data[0];
        if (!dwait) begin
          next_state = dcache_pkg::WB2;
        end
      end

      dcache_pkg::WB2: begin
        dWEN   = 1'b1;
        daddr  = {victim_tag, rq_index, 1'b1, BYTE0};
        dstore = victim_data[1];
        if (!dwait) begin
          next_state = dcache_pkg::FETCH1;
        end
      end

      dcache_pkg::FLUSH1, dcache_pkg::FLUSH2,
      dcache_pkg::FLUSH3, dcache_pkg::FLUSH4: begin
        dWEN   = fsel_dirty; // clean words cost one cycle and no access
        daddr  = {fsel_tag, fl_index, fl_word, BYTE0};
        dstore = fsel_data[fl_word];
        if (!dwait || !fsel_dirty) begin
          if (state == dcache_pkg::FLUSH4) begin
            fl_inc = 1'b1;
            if (fl_index == dcache_pkg::idx_t'(dcache_pkg::NUM_SETS - 1)) begin
              next_state = dcache_pkg::DONE;
            end else begin
              next_state = dcache_pkg::FLUSH1;
            end
          end else begin
            next_state = dcache_pkg::ctrl_state_t'(state + 1'b1);
          end
        end
      end

      dcache_pkg::DONE: begin
        clear = 1'b1; // stays here with the array held empty
      end

      default: begin
        next_state = dcache_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state    <= dcache_pkg::IDLE;
      fl_index <= '0;
    end else begin
      state <= next_state;
      if (fl_inc) begin
        fl_index <= fl_index + 1'b1; // next set after way 1 word 1
      end
    end
  end

endmodule

//--- logic/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
  input  logic              CLK,
  input  logic              nRST,
  // processor
  input  dcache_pkg::word_t dmemaddr,
  input  logic              dmemREN,
  input  logic              dmemWEN,
  input  dcache_pkg::word_t dmemstore,
  input  logic              halt,
  output logic              dhit,
  output dcache_pkg::word_t dmemload,
  output logic              flushed,
  // memory
  output logic              dREN,
  output logic              dWEN,
  output dcache_pkg::word_t daddr,
  output dcache_pkg::word_t dstore,
  input  dcache_pkg::word_t dload,
  input  logic              dwait
);

  // requested set from array to lookup
  dcache_pkg::idx_t rq_index;
  dcache_pkg::tag_t rq_tag0, rq_tag1;
  logic rq_valid0, rq_valid1, rq_dirty0, rq_dirty1, rq_lru;
  dcache_pkg::word_t [dcache_pkg::BLOCK_WORDS-1:0] rq_data0, rq_data1;

  // flush set from array to controller
  dcache_pkg::idx_t fl_index;
  dcache_pkg::tag_t fl_tag0, fl_tag1;
  logic fl_dirty0, fl_dirty1;
  dcache_pkg::word_t [dcache_pkg::BLOCK_WORDS-1:0] fl_data0, fl_data1;

  // lookup to controller
  logic hit, hit_way, victim_way, victim_valid, victim_dirty;
  dcache_pkg::tag_t victim_tag;
  dcache_pkg::word_t [dcache_pkg::BLOCK_WORDS-1:0] victim_data;

  // controller to array
  logic wen, wr_way, wr_word, wr_valid, wr_dirty, clear, lru_wen, lru_val;
  dcache_pkg::idx_t wr_index;
  dcache_pkg::tag_t wr_tag;
  dcache_pkg::word_t wr_data;

  assign dhit = hit; // combinational in the request cycle

  dcache_array array_i (
    .CLK, .nRST, .rq_index, .fl_index,
    .wen, .wr_way, .wr_index, .wr_word, .wr_tag, .wr_data, .wr_valid, .wr_dirty,
    .clear, .lru_wen, .lru_val,
    .rq_tag0, .rq_tag1, .rq_valid0, .rq_valid1, .rq_dirty0, .rq_dirty1,
    .rq_data0, .rq_data1, .rq_lru,
    .fl_tag0, .fl_tag1, .fl_dirty0, .fl_dirty1, .fl_data0, .fl_data1
  );

  dcache_lookup lookup_i (
    .dmemaddr, .dmemREN, .dmemWEN,
    .rq_tag0, .rq_tag1, .rq_valid0, .rq_valid1, .rq_dirty0, .rq_dirty1,
    .rq_data0, .rq_data1, .rq_lru,
    .rq_index, .hit, .hit_way, .dmemload,
    .victim_way, .victim_valid, .victim_dirty, .victim_tag, .victim_data
  );

  dcache_ctrl ctrl_i (
    .CLK, .nRST, .dmemaddr, .dmemREN, .dmemWEN, .dmemstore, .halt, .flushed,
    .hit, .hit_way, .victim_way, .victim_valid, .victim_dirty, .victim_tag, .victim_data,
    .fl_tag0, .fl_tag1, .fl_dirty0, .fl_dirty1, .fl_data0, .fl_data1, .fl_index,
    .wen, .wr_way, .wr_index, .wr_word, .wr_tag, .wr_data, .wr_valid, .wr_dirty,
    .clear, .lru_wen, .lru_val,
    .dREN, .dWEN, .daddr, .dstore, .dload, .dwait
  );

endmodule

//--- test/dcache_assert.sv
`timescale 1ns/1ps

module dcache_assert (
  input logic                    CLK,
  input logic                    nRST,
  input logic                    dREN,
  input logic                    dWEN,
  input logic                    dwait,
  input logic                    flushed,
  input dcache_pkg::word_t       daddr,
  input dcache_pkg::ctrl_state_t state
);

  int fail_count = 0; // number of failed assertions

  // one memory access at a time
  a_rw_excl: assert property (@(posedge CLK) disable iff (!nRST) !(dREN && dWEN))
    else begin
      $error("dREN and dWEN high together");
      fail_count++;
    end

  a_flushed_sticky: assert property (@(posedge CLK) disable iff (!nRST)
    flushed |=> flushed)
    else begin
      $error("flushed dropped before reset");
      fail_count++;
    end

  // a stalled access keeps its address
  a_addr_stable: assert property (@(posedge CLK) disable iff (!nRST)
    (dREN || dWEN) && dwait |=> $stable(daddr))
    else begin
      $error("daddr changed while dwait was high");
      fail_count++;
    end

  // back-pressure freezes the controller
  a_state_hold: assert property (@(posedge CLK) disable iff (!nRST)
    (dREN || dWEN) && dwait |=> $stable(state))
    else begin
      $error("controller state moved while dwait was high");
      fail_count++;
    end

endmodule

//--- test/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;

  localparam int MEM_WORDS = 64;
  localparam int MAX_WAIT  = 4; // up to 3 stall cycles plus the access cycle

  logic CLK = 1'b0;
  logic nRST;
  logic dmemREN, dmemWEN, halt, dhit, flushed, dREN, dWEN, dwait;
  dcache_pkg::word_t dmemaddr, dmemstore, dmemload, daddr, dstore, dload;

  dcache_pkg::word_t mem [MEM_WORDS];     // memory model indexed by addr[7:2]
  dcache_pkg::word_t exp_mem [MEM_WORDS]; // last value written by the processor
  byte               op_q [$];
  dcache_pkg::word_t addr_q [$];
  dcache_pkg::word_t data_q [$];
  dcache_pkg::word_t exp_q [$];
  integer seed = 32'h1e41;
  int wait_cnt;
  int cycles = 0;
  int limit = 0;
  int errors = 0;
  int tests_failed = 0;
  bit opened;

  dcache_top dcache_top_i (.*);

  bind dcache_ctrl dcache_assert ctrl_assert_i (
    .CLK, .nRST, .dREN, .dWEN, .dwait, .flushed, .daddr, .state
  );

  always #20 CLK = ~CLK;

  // memory model stalls each access randomly and moves the word when dwait is low
  always @(negedge CLK) begin
    if (dREN || dWEN) begin
      if (wait_cnt != 0) begin
        dwait    <= 1'b1;
        wait_cnt <= wait_cnt - 1;
      end else begin
        dwait <= 1'b0; // completes at the next rising edge
        dload <= mem[daddr[7:2]];
        if (dWEN) begin
          mem[daddr[7:2]] <= dstore;
        end
        wait_cnt <= $random(seed) & 3; // stall for the next access
      end
    end else begin
      dwait <= 1'b0;
    end
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (limit != 0 && cycles >= limit) begin
      $display("timeout: no result after %0d cycles", cycles);
      $display("sim failed");
      $finish;
    end
  end

  task automatic check_word(input string name, input dcache_pkg::word_t got,
                            input dcache_pkg::word_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic read_stimulus(output bit ok);
    int fd;
    string line;
    byte op;
    dcache_pkg::word_t a, d, e;
    fd = $fopen("test/dcache_stimulus.txt", "r");
    ok = (fd != 0);
    if (ok) begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() < 4 || line.substr(0, 0) == "#") begin
          continue; // blank or comment line
        end
        void'($sscanf(line, "%c %h %h %h", op, a, d, e));
        op_q.push_back(op);
        addr_q.push_back(a);
        data_q.push_back(d);
        exp_q.push_back(e);
      end
      $fclose(fd);
    end
  endtask

  // memory strobes, hit and flushed all low out of reset
  task automatic check_reset_state();
    int err0;
    err0 = errors;
    @(posedge CLK);
    check_bit("dREN", dREN, 1'b0);
    check_bit("dWEN", dWEN, 1'b0);
    check_bit("dhit", dhit, 1'b0);
    check_bit("flushed", flushed, 1'b0);
    if (errors != err0) begin
      tests_failed++;
    end
    $display("test reset %s", (errors == err0) ? "ok" : "FAIL");
  endtask

  task automatic run_op(input int n);
    int err0;
    err0 = errors;
    @(negedge CLK);
    dmemaddr  <= addr_q[n];
    dmemstore <= data_q[n];
    dmemREN   <= (op_q[n] == "R");
    dmemWEN   <= (op_q[n] == "W");
    halt      <= (op_q[n] == "H");
    case (op_q[n])
      "R": begin
        do @(posedge CLK); while (!dhit); // miss latency varies
        check_word("dmemload", dmemload, exp_q[n]);
      end
      "W": begin
        do @(posedge CLK); while (!dhit); // word lands on this edge
        exp_mem[addr_q[n][7:2]] = data_q[n];
      end
      "H": begin
        do @(posedge CLK); while (!flushed);
        repeat (4) @(posedge CLK);
        check_bit("flushed", flushed, 1'b1); // sticky
        for (int i = 0; i < MEM_WORDS; i++) begin
          check_word($sformatf("mem[%02h]", i * 4), mem[i], exp_mem[i]);
        end
      end
      default: begin
        $display("test %0d has an unknown opcode %c", n, op_q[n]);
        errors++;
      end
    endcase
    if (errors != err0) begin
      tests_failed++;
    end
    $display("test %0d %c %h %s", n, op_q[n], addr_q[n], (errors == err0) ? "ok" : "FAIL");
  endtask

  initial begin
    nRST      = 1'b0;
    dmemaddr  = '0;
    dmemstore = '0;
    dmemREN   = 1'b0;
    dmemWEN   = 1'b0;
    halt      = 1'b0;
    dwait     = 1'b0;
    dload     = '0;
    wait_cnt  = $random(seed) & 3;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i]     = ~dcache_pkg::word_t'(i * 4); // inverted byte address
      exp_mem[i] = ~dcache_pkg::word_t'(i * 4);
    end
    read_stimulus(opened);
    if (!opened) begin
      $display("cannot open the stimulus file test/dcache_stimulus.txt");
      $display("sim failed");
      $finish;
    end else begin
      // worst case per op is a dirty miss with 32 flush words and reset on top
      limit = 8 + op_q.size() * 4 * MAX_WAIT + 32 * MAX_WAIT + 100;
      repeat (8) @(negedge CLK);
      nRST <= 1'b1;
      check_reset_state();
      for (int n = 0; n < op_q.size(); n++) begin
        run_op(n);
      end
      errors += dcache_top_i.ctrl_i.ctrl_assert_i.fail_count; // bound assertion failures
      $display("tests %0d failed %0d errors %0d", op_q.size() + 1, tests_failed, errors);
      if (errors == 0) begin
        $display("sim passed");
      end else begin
        $display("sim failed");
      end
      $finish;
    end
  end

endmodule

//--- test/dcache_stimulus.txt
# op addr store expected_load, all values in hex
# op R reads and checks the load, W writes, H halts and checks memory after the flush
R 00000000 00000000 ffffffff
R 00000004 00000000 fffffffb
W 00000010 11110010 00000000
R 00000010 00000000 11110010
R 00000014 00000000 ffffffeb
W 00000008 aaaa0008 00000000
W 0000004c bbbb004c 00000000
R 00000008 00000000 aaaa0008
R 00000088 00000000 ffffff77
R 00000048 00000000 ffffffb7
R 0000004c 00000000 bbbb004c
R 00000008 00000000 aaaa0008
R 0000000c 00000000 fffffff3
W 000000f8 cccc00f8 00000000
W 00000010 22220010 00000000
R 00000010 00000000 22220010
W 000000c8 dddd00c8 00000000
R 000000c8 00000000 dddd00c8
R 000000cc 00000000 ffffff33
H 00000000 00000000 00000000

//--- sources.f
logic/dcache_pkg.sv
logic/dcache_array.sv
logic/dcache_lookup.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
test/dcache_assert.sv
test/dcache_tb.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - logic/dcache_pkg.sv
  - logic/dcache_array.sv
  - logic/dcache_lookup.sv
  - logic/dcache_ctrl.sv
  - logic/dcache_top.sv
  - target: test
    files:
      - test/dcache_assert.sv
      - test/dcache_tb.sv
